/* Bender.yml */
package:
  name: timer

sources:
  - logic/timer_pkg.sv
  - logic/chan_cfg_if.sv
  - logic/timer_cfg_regs.sv
  - logic/timer_counter.sv
  - logic/timer_ic_oc.sv
  - logic/cap_event_queue.sv
  - logic/timer_top.sv
  - target: test
    files:
      - dv/timer_tb.sv

/* compile.f */
logic/timer_pkg.sv
logic/chan_cfg_if.sv
logic/timer_cfg_regs.sv
logic/timer_counter.sv
logic/timer_ic_oc.sv
logic/cap_event_queue.sv
logic/timer_top.sv
dv/timer_tb.sv

/* dv/timer_tb.sv */
`timescale 1ns/100ps
/* timer_tb
   runs the timer through compare PWM, compare shadowing, capture, filter and back-pressure */
module timer_tb;

    localparam int CLK_PERIOD  = 20;
    localparam int PWM_PERIOD  = 20; // (arr 9 + 1) * (psc 1 + 1)
    localparam int PSC_CAP     = 63; // prescaler during the capture tests
    localparam int N_CAPS      = 11;
    localparam int TEST_CYCLES = 16 + 6 * PWM_PERIOD + N_CAPS * 2 * (PSC_CAP + 1) + 300;

    logic                          clk = 1'b0;
    logic                          resetn;
    logic                          cfg_valid;
    logic [timer_pkg::ADDR_W-1:0]  cfg_addr;
    logic [timer_pkg::TIMER_W-1:0] cfg_data;
    logic                          cap_valid;
    logic                          cap_ready;
    logic [timer_pkg::CH_W-1:0]    cap_chan;
    logic [timer_pkg::TIMER_W-1:0] cap_value;
    logic [timer_pkg::NUM_CH-1:0]  cap_in;
    logic [timer_pkg::NUM_CH-1:0]  cmp_out;
    logic [timer_pkg::NUM_CH-1:0]  cap_cmp_t;
    logic                          ovf;

    timer_pkg::cap_event_t         got_evt;
    timer_pkg::cap_event_t         exp_q [$]; // expected transfers, oldest first

    // reference state of counter and channels
    logic                          m_en;
    logic [timer_pkg::TIMER_W-1:0] m_psc;
    logic [timer_pkg::TIMER_W-1:0] m_arr;
    logic [timer_pkg::TIMER_W-1:0] m_cnt;
    logic [timer_pkg::TIMER_W-1:0] m_pcnt;
    logic                          m_tick;
    logic                          m_wrap;
    logic                          m_sel    [timer_pkg::NUM_CH];
    logic                          m_oen    [timer_pkg::NUM_CH];
    timer_pkg::oc_mode_e           m_mode   [timer_pkg::NUM_CH];
    logic [timer_pkg::TIMER_W-1:0] m_cmp    [timer_pkg::NUM_CH];
    logic [timer_pkg::TIMER_W-1:0] m_shadow [timer_pkg::NUM_CH];
    logic [timer_pkg::NUM_CH-1:0]  exp_pin;
    logic [timer_pkg::NUM_CH-1:0]  exp_dir;

    logic [31:0]                   stim_seed  = 32'd15;
    logic [31:0]                   ready_seed = 32'd15;
    logic                          ready_rand;  // random stalls on cap_ready
    logic                          ready_level; // fixed cap_ready otherwise

    timer_top i_dut (
        .clk, .resetn, .cfg_valid, .cfg_addr, .cfg_data,
        .cap_valid, .cap_ready, .cap_chan, .cap_value,
        .cap_in, .cmp_out, .cap_cmp_t, .ovf
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    assign got_evt = {cap_chan, cap_value};
    assign m_tick  = m_en && (m_pcnt == m_psc); // one tick per psc+1 cycles
    assign m_wrap  = m_tick && (m_cnt == m_arr);

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic int unsigned draw_rand();
        stim_seed = lcg_next(stim_seed);
        return stim_seed[23:8];
    endfunction

    function automatic logic [timer_pkg::ADDR_W-1:0] ch_ctrl_addr(input int ch);
        return timer_pkg::REG_CH_CTRL + 2 * ch;
    endfunction

    function automatic logic [timer_pkg::ADDR_W-1:0] ch_cmp_addr(input int ch);
        return timer_pkg::REG_CH_CMP + 2 * ch;
    endfunction

    // compare rule of one channel
    function automatic logic ref_pin(input timer_pkg::oc_mode_e mode,
                                     input logic [timer_pkg::TIMER_W-1:0] cnt_v,
                                     input logic [timer_pkg::TIMER_W-1:0] cmp_v);
        case (mode)
            timer_pkg::OC_GEQ_HIGH: return cnt_v >= cmp_v;
            timer_pkg::OC_LT_HIGH:  return cnt_v < cmp_v;
            default:                return 1'b0;
        endcase
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("*** FAILED ***");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_bits(input string name, input logic [timer_pkg::NUM_CH-1:0] got,
                              input logic [timer_pkg::NUM_CH-1:0] exp);
        if (got !== exp)
            report_failure($sformatf("FAIL t=%0t %s got %b expected %b", $time, name, got, exp));
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
            report_failure($sformatf("FAIL t=%0t %s got %b expected %b", $time, name, got, exp));
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp)
            report_failure($sformatf("FAIL t=%0t %s got %0d expected %0d", $time, name, got, exp));
    endtask

    task automatic check_event(input timer_pkg::cap_event_t got, input timer_pkg::cap_event_t exp);
        if (got !== exp)
            report_failure($sformatf("FAIL t=%0t cap_event got ch%0d/%h expected ch%0d/%h",
                                     $time, got.chan, got.value, exp.chan, exp.value));
    endtask

    // one register write, driven on the falling edge
    task automatic write_reg(input logic [timer_pkg::ADDR_W-1:0] addr,
                             input logic [timer_pkg::TIMER_W-1:0] data);
        @(negedge clk);
        cfg_valid = 1'b1;
        cfg_addr  = addr;
        cfg_data  = data;
        @(negedge clk);
        cfg_valid = 1'b0;
    endtask

    // first cycle of a count period, checked at the current edge first
    task automatic wait_period_start();
        while (!(m_cnt == '0 && m_pcnt == '0))
            @(negedge clk);
    endtask

    task automatic count_highs(output int n0, output int n1);
        n0 = 0;
        n1 = 0;
        repeat (PWM_PERIOD)
        begin
            @(negedge clk);
            n0 += cmp_out[0];
            n1 += cmp_out[1];
        end
    endtask

    // new level on a pin mid prescale interval, so the count holds through detection
    task automatic drive_capture(input int ch, input logic level, input bit stored);
        timer_pkg::cap_event_t evt;
        @(negedge clk);
        while (m_pcnt != 16)
            @(negedge clk);
        evt.chan  = ch[timer_pkg::CH_W-1:0];
        evt.value = m_cnt;
        if (stored)
            exp_q.push_back(evt);
        cap_in[ch] = level;
    endtask

    task automatic wait_drained();
        while (exp_q.size() != 0)
            @(negedge clk);
        repeat (40) @(negedge clk); // room for a stray extra event
    endtask

    // reference counter, shadow and pins, one step per clock
    always @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            m_en    <= 1'b0;
            m_psc   <= '0;
            m_arr   <= '1;
            m_cnt   <= '0;
            m_pcnt  <= '0;
            exp_pin <= '0;
            exp_dir <= '1; // pads are inputs
            for (int ch = 0; ch < timer_pkg::NUM_CH; ch++)
            begin
                m_sel[ch]    <= 1'b0;
                m_oen[ch]    <= 1'b0;
                m_mode[ch]   <= timer_pkg::OC_GEQ_HIGH;
                m_cmp[ch]    <= '0;
                m_shadow[ch] <= '0;
            end
        end
        else
        begin
            for (int ch = 0; ch < timer_pkg::NUM_CH; ch++)
            begin
                exp_pin[ch] <= m_en && m_sel[ch] && m_oen[ch]
                               && ref_pin(m_mode[ch], m_cnt, m_shadow[ch]);
                exp_dir[ch] <= !(m_en && m_sel[ch] && m_oen[ch]);
                if (!m_en || m_wrap)
                    m_shadow[ch] <= m_cmp[ch]; // period boundary or stopped
                if (cfg_valid && cfg_addr == ch_ctrl_addr(ch))
                begin
                    m_sel[ch]  <= cfg_data[0];
                    m_oen[ch]  <= cfg_data[1];
                    m_mode[ch] <= timer_pkg::oc_mode_e'(cfg_data[3:2]);
                end
                if (cfg_valid && cfg_addr == ch_cmp_addr(ch))
                    m_cmp[ch] <= cfg_data;
            end
            if (!m_en)
            begin
                m_cnt  <= '0;
                m_pcnt <= '0;
            end
            else if (m_tick)
            begin
                m_pcnt <= '0;
                m_cnt  <= m_wrap ? '0 : m_cnt + 1'b1;
            end
            else
                m_pcnt <= m_pcnt + 1'b1;
            if (cfg_valid && cfg_addr == timer_pkg::REG_CTRL)
                m_en <= cfg_data[0];
            if (cfg_valid && cfg_addr == timer_pkg::REG_PSC)
                m_psc <= cfg_data;
            if (cfg_valid && cfg_addr == timer_pkg::REG_ARR)
                m_arr <= cfg_data;
        end
    end

    // pins against the reference every cycle
    always @(negedge clk)
    begin
        if (resetn)
        begin
            check_bits("cmp_out", cmp_out, exp_pin);
            check_bits("cap_cmp_t", cap_cmp_t, exp_dir);
        end
    end

    // drives cap_ready, then checks the transfer that this ready value allows
    always @(negedge clk)
    begin
        if (ready_rand)
        begin
            ready_seed = lcg_next(ready_seed);
            cap_ready  = ready_seed[19];
        end
        else
            cap_ready = ready_level;
        if (resetn && cap_valid && cap_ready)
        begin
            if (exp_q.size() == 0)
                report_failure("a capture event was transferred although none was expected");
            else
                check_event(got_evt, exp_q.pop_front());
        end
    end

    initial
    begin
        #(CLK_PERIOD * 40 * TEST_CYCLES);
        report_failure("watchdog timeout, the tests did not finish in time");
    end

    initial
    begin
        int c_old;
        int c_new;
        int n0;
        int n1;

        resetn      = 1'b0;
        cfg_valid   = 1'b0;
        cfg_addr    = '0;
        cfg_data    = '0;
        cap_in      = '0;
        cap_ready   = 1'b0;
        ready_rand  = 1'b0;
        ready_level = 1'b1;
        repeat (16) @(negedge clk);
        resetn = 1'b1;

        // reset state
        repeat (4) @(negedge clk);
        check_flag("cap_valid", cap_valid, 1'b0);
        check_flag("ovf", ovf, 1'b0);
        check_bits("cmp_out", cmp_out, '0);
        check_bits("cap_cmp_t", cap_cmp_t, '1);

        // PWM, ch0 high from c, ch1 high below c
        c_old = 1 + draw_rand() % 9;
        write_reg(ch_ctrl_addr(0), 16'h0003);
        write_reg(ch_cmp_addr(0), c_old);
        write_reg(ch_ctrl_addr(1), 16'h0007);
        write_reg(ch_cmp_addr(1), c_old);
        write_reg(timer_pkg::REG_PSC, 16'd1);
        write_reg(timer_pkg::REG_ARR, 16'd9);
        write_reg(timer_pkg::REG_CTRL, 16'h0001);
        wait_period_start();
        count_highs(n0, n1);
        check_count("ch0 high cycles", n0, (10 - c_old) * 2);
        check_count("ch1 high cycles", n1, c_old * 2);
        check_bits("cap_cmp_t", cap_cmp_t, '0);

        // new compare mid period only counts from the next period on
        c_new = 1 + (c_old + draw_rand() % 8) % 9;
        wait_period_start();
        fork
            count_highs(n0, n1);
            begin
                repeat (6) @(negedge clk);
                write_reg(ch_cmp_addr(0), c_new);
                write_reg(ch_cmp_addr(1), c_new);
            end
        join
        check_count("ch0 high cycles, old compare", n0, (10 - c_old) * 2);
        check_count("ch1 high cycles, old compare", n1, c_old * 2);
        count_highs(n0, n1);
        check_count("ch0 high cycles, new compare", n0, (10 - c_new) * 2);
        check_count("ch1 high cycles, new compare", n1, c_new * 2);

        // capture, ch1 rising edge then ch0 on both edges
        write_reg(timer_pkg::REG_CTRL, 16'h0000);
        write_reg(timer_pkg::REG_PSC, PSC_CAP);
        write_reg(timer_pkg::REG_ARR, 16'd1000);
        write_reg(ch_ctrl_addr(1), 16'h0000);
        write_reg(ch_ctrl_addr(0), 16'h0020);
        write_reg(timer_pkg::REG_CTRL, 16'h0001);
        ready_rand = 1'b1;
        drive_capture(1, 1'b1, 1'b1);
        wait_drained();
        cap_in[1] = 1'b0; // falling edge not selected
        drive_capture(0, 1'b1, 1'b1);
        wait_drained();
        drive_capture(0, 1'b0, 1'b1);
        wait_drained();

        // filter threshold 8, short glitch dropped, long level kept
        write_reg(ch_ctrl_addr(1), 16'h0800);
        drive_capture(1, 1'b1, 1'b0);
        repeat (4) @(negedge clk);
        cap_in[1] = 1'b0;
        repeat (40) @(negedge clk);
        check_flag("cap_valid", cap_valid, 1'b0);
        drive_capture(1, 1'b1, 1'b1);
        repeat (20) @(negedge clk);
        cap_in[1] = 1'b0;
        wait_drained();

        // six captures into a stalled queue, the last two dropped
        write_reg(ch_ctrl_addr(1), 16'h0000);
        ready_rand  = 1'b0;
        ready_level = 1'b0;
        for (int k = 0; k < 6; k++)
        begin
            drive_capture(1, 1'b1, k < timer_pkg::QUEUE_DEPTH);
            repeat (8) @(negedge clk);
            cap_in[1] = 1'b0;
            repeat (4) @(negedge clk);
            if (k == 3)
            begin
                check_flag("ovf", ovf, 1'b0); // full but nothing lost yet
                check_flag("cap_valid", cap_valid, 1'b1);
            end
        end
        check_flag("ovf", ovf, 1'b1);
        ready_rand = 1'b1;
        wait_drained();
        check_flag("cap_valid", cap_valid, 1'b0);
        write_reg(timer_pkg::REG_CTRL, 16'h0003); // keep running, clear ovf
        repeat (3) @(negedge clk);
        check_flag("ovf", ovf, 1'b0);

        repeat (10) @(negedge clk);
        $display("*** PASSED ***");
        $finish;
    end

endmodule

/* logic/cap_event_queue.sv */
`timescale 1ns/100ps
/* cap_event_queue
   four-entry capture queue, channel 0 first, valid/ready out and sticky overflow */
module cap_event_queue (
    input  logic                          clk,
    input  logic                          resetn,
    input  logic [timer_pkg::NUM_CH-1:0]  cap_evt,
    input  logic [timer_pkg::TIMER_W-1:0] cap_val [timer_pkg::NUM_CH],
    input  logic                          ovf_clr,
    output logic                          cap_valid,
    input  logic                          cap_ready,
    output logic [timer_pkg::CH_W-1:0]    cap_chan,
    output logic [timer_pkg::TIMER_W-1:0] cap_value,
    output logic                          ovf
);

    timer_pkg::cap_event_t          mem [timer_pkg::QUEUE_DEPTH];
    logic [timer_pkg::QPTR_W-1:0]   wr_ptr;
    logic [timer_pkg::QPTR_W-1:0]   rd_ptr;
    logic [timer_pkg::QPTR_W:0]     count;  // entries held
    logic [timer_pkg::QPTR_W:0]     n_push; // pushes this cycle
    logic [timer_pkg::NUM_CH-1:0]   push_ok;
    logic [timer_pkg::QPTR_W-1:0]   wr_idx [timer_pkg::NUM_CH];
    logic                           drop;
    logic                           pop;

    assign cap_valid = count != '0;
    assign pop       = cap_valid && cap_ready;
    assign cap_chan  = mem[rd_ptr].chan;
    assign cap_value = mem[rd_ptr].value;

    // lowest channel takes the first free slot, a pop frees nothing this cycle
    always_comb
    begin
        n_push = '0;
        drop   = 1'b0;
        for (int ch = 0; ch < timer_pkg::NUM_CH; ch++)
        begin
            wr_idx[ch]  = wr_ptr + n_push[timer_pkg::QPTR_W-1:0]; // wraps at depth
            push_ok[ch] = 1'b0;
            if (cap_evt[ch])
            begin
                if (count + n_push < timer_pkg::QUEUE_DEPTH)
                begin
                    push_ok[ch] = 1'b1;
                    n_push      = n_push + 1'b1;
                end
                else
                    drop = 1'b1; // full
            end
        end
    end

    always_ff @(posedge clk)
    begin
        for (int ch = 0; ch < timer_pkg::NUM_CH; ch++)
            if (push_ok[ch])
                mem[wr_idx[ch]] <= '{chan: ch[timer_pkg::CH_W-1:0], value: cap_val[ch]};
    end

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            ovf    <= 1'b0;
        end
        else
        begin
            wr_ptr <= wr_ptr + n_push[timer_pkg::QPTR_W-1:0];
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            count <= count + n_push - {{timer_pkg::QPTR_W{1'b0}}, pop};
            if (drop)
                ovf <= 1'b1; // a new drop outranks a clear
            else if (ovf_clr)
                ovf <= 1'b0;
        end
    end

    assert property (@(posedge clk) disable iff (!resetn)
        count <= timer_pkg::QUEUE_DEPTH);

    // held head stays put until the transfer
    assert property (@(posedge clk) disable iff (!resetn)
        cap_valid && !cap_ready |=> cap_valid && $stable(cap_chan) && $stable(cap_value));

endmodule

/* logic/chan_cfg_if.sv */
`timescale 1ns/100ps
/* chan_cfg_if
   settings of one capture/compare channel, register block to channel */
interface chan_cfg_if;

    logic                          cap_cmp_sel; // 1 selects compare
    logic                          cmp_oen;     // pin drive enable in compare
    timer_pkg::oc_mode_e           oc_mode;
    timer_pkg::cap_edge_e          cap_edge;
    logic [timer_pkg::FILT_W-1:0]  filter_th;
    logic [timer_pkg::TIMER_W-1:0] cmp_val;     // unshadowed compare value

    // register side
    modport regs (
        output cap_cmp_sel, cmp_oen, oc_mode, cap_edge, filter_th, cmp_val
    );

    // channel side, read only
    modport chan (
        input cap_cmp_sel, cmp_oen, oc_mode, cap_edge, filter_th, cmp_val
    );

endinterface

/* logic/timer_cfg_regs.sv */
`timescale 1ns/100ps
/* timer_cfg_regs
   write-only register block, decodes cfg writes into timer and channel settings */
module timer_cfg_regs (
    input  logic                          clk,
    input  logic                          resetn,
    input  logic                          cfg_valid,
    input  logic [timer_pkg::ADDR_W-1:0]  cfg_addr,
    input  logic [timer_pkg::TIMER_W-1:0] cfg_data,
    output logic                          enable,
    output logic [timer_pkg::TIMER_W-1:0] psc,
    output logic [timer_pkg::TIMER_W-1:0] arr,
    output logic                          ovf_clr,
    chan_cfg_if.regs                      ch_cfg [timer_pkg::NUM_CH]
);

    logic wr_ctrl;
    logic wr_psc;
    logic wr_arr;

    assign wr_ctrl = cfg_valid && (cfg_addr == timer_pkg::REG_CTRL);
    assign wr_psc  = cfg_valid && (cfg_addr == timer_pkg::REG_PSC);
    assign wr_arr  = cfg_valid && (cfg_addr == timer_pkg::REG_ARR);

    // global timer settings
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            enable  <= 1'b0;
            psc     <= '0;
            arr     <= '1; // free running full range until programmed
            ovf_clr <= 1'b0;
        end
        else
        begin
            ovf_clr <= wr_ctrl && cfg_data[1]; // pulse, not stored
            if (wr_ctrl)
                enable <= cfg_data[0];
            if (wr_psc)
                psc <= cfg_data;
            if (wr_arr)
                arr <= cfg_data;
        end
    end

    // per channel control word and compare value
    for (genvar g = 0; g < timer_pkg::NUM_CH; g++)
    begin : g_ch
        localparam int unsigned CTRL_A = timer_pkg::REG_CH_CTRL + 2 * g;
        localparam int unsigned CMP_A  = timer_pkg::REG_CH_CMP + 2 * g;

        logic wr_ch_ctrl;
        logic wr_ch_cmp;

        assign wr_ch_ctrl = cfg_valid && (cfg_addr == CTRL_A[timer_pkg::ADDR_W-1:0]);
        assign wr_ch_cmp  = cfg_valid && (cfg_addr == CMP_A[timer_pkg::ADDR_W-1:0]);

        always_ff @(posedge clk or negedge resetn)
        begin
            if (!resetn)
            begin
                ch_cfg[g].cap_cmp_sel <= 1'b0; // capture after reset
                ch_cfg[g].cmp_oen     <= 1'b0;
                ch_cfg[g].oc_mode     <= timer_pkg::OC_GEQ_HIGH;
                ch_cfg[g].cap_edge    <= timer_pkg::EDGE_RISE;
                ch_cfg[g].filter_th   <= '0;
                ch_cfg[g].cmp_val     <= '0;
            end
            else
            begin
                if (wr_ch_ctrl)
                begin
                    ch_cfg[g].cap_cmp_sel <= cfg_data[0];
                    ch_cfg[g].cmp_oen     <= cfg_data[1];
                    ch_cfg[g].oc_mode     <= timer_pkg::oc_mode_e'(cfg_data[3:2]);
                    ch_cfg[g].cap_edge    <= timer_pkg::cap_edge_e'(cfg_data[5:4]);
                    ch_cfg[g].filter_th   <= cfg_data[8 +: timer_pkg::FILT_W];
                end
                if (wr_ch_cmp)
                    ch_cfg[g].cmp_val <= cfg_data;
            end
        end
    end

endmodule

/* logic/timer_counter.sv */
`timescale 1ns/100ps
/* timer_counter
   prescaled up-counter with auto-reload, flags the wrap cycle */
module timer_counter (
    input  logic                          clk,
    input  logic                          resetn,
    input  logic                          enable,
    input  logic [timer_pkg::TIMER_W-1:0] psc,
    input  logic [timer_pkg::TIMER_W-1:0] arr,
    output logic [timer_pkg::TIMER_W-1:0] cnt,
    output logic                          running,
    output logic                          expired
);

    logic [timer_pkg::TIMER_W-1:0] psc_cnt; // prescaler position
    logic                          tick;    // one count step
    logic                          at_top;

    assign running = enable;

    // >= so a smaller psc or arr written on the fly still ends the interval
    assign tick    = enable && (psc_cnt >= psc);
    assign at_top  = cnt >= arr;
    assign expired = tick && at_top; // wrap happens at the end of this cycle

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            psc_cnt <= '0;
            cnt     <= '0;
        end
        else if (!enable)
        begin
            psc_cnt <= '0; // stopped timer restarts from zero
            cnt     <= '0;
        end
        else if (tick)
        begin
            psc_cnt <= '0;
            cnt     <= at_top ? '0 : cnt + 1'b1;
        end
        else
        begin
            psc_cnt <= psc_cnt + 1'b1;
        end
    end

    // wrap only while running, and the count really is zero afterwards
    assert property (@(posedge clk) disable iff (!resetn)
        expired |-> running ##1 (cnt == '0));

endmodule

/* logic/timer_ic_oc.sv */
`timescale 1ns/100ps
/* timer_ic_oc
   one channel, filtered input capture or output compare with shadowed compare value */
module timer_ic_oc (
    input  logic                          clk,
    input  logic                          resetn,
    input  logic                          cap_in,
    output logic                          cmp_out,
    output logic                          cap_cmp_t, // pad direction, 0 drives
    input  logic [timer_pkg::TIMER_W-1:0] cnt,
    input  logic                          running,
    input  logic                          expired,
    chan_cfg_if.chan                      cfg,
    output logic                          cap_evt,
    output logic [timer_pkg::TIMER_W-1:0] cap_val
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_DELAY,   // filter wait
        ST_CONFIRM, // level check
        ST_CAP      // event cycle
    } cap_state_e;

    cap_state_e                    state;
    logic [2:0]                    sync;     // two sync flops then the edge flop
    logic                          rise;
    logic                          fall;
    logic                          edge_hit;
    logic                          cap_start;
    logic                          dir_q;    // 1 when a rise started the filter
    logic [timer_pkg::FILT_W-1:0]  th_q;
    logic [timer_pkg::FILT_W-1:0]  filt_cnt;
    logic                          filt_done;
    logic [timer_pkg::TIMER_W-1:0] cmp_shadow;
    logic                          cmp_active;
    logic                          cmp_next;

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
            sync <= 3'b000;
        else
            sync <= {sync[1:0], cap_in};
    end

    assign rise = sync[1] & ~sync[2];
    assign fall = ~sync[1] & sync[2];

    always_comb
    begin
        case (cfg.cap_edge)
            timer_pkg::EDGE_RISE: edge_hit = rise;
            timer_pkg::EDGE_FALL: edge_hit = fall;
            timer_pkg::EDGE_BOTH: edge_hit = rise | fall;
            default:              edge_hit = 1'b0; // reserved code
        endcase
    end

    // edges are ignored while a filter run is in progress
    assign cap_start = edge_hit && running && !cfg.cap_cmp_sel && (state == ST_IDLE);
    assign filt_done = filt_cnt == th_q;

    // count, direction and threshold frozen at detection
    always_ff @(posedge clk)
    begin
        if (cap_start)
        begin
            cap_val <= cnt;
            dir_q   <= rise;
            th_q    <= cfg.filter_th;
        end
    end

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
            filt_cnt <= '0;
        else if (state == ST_DELAY)
            filt_cnt <= filt_cnt + 1'b1;
        else
            filt_cnt <= '0;
    end

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
            state <= ST_IDLE;
        else if (cfg.cap_cmp_sel || !running)
            state <= ST_IDLE; // abort on mode switch or stop
        else
        begin
            case (state)
                ST_IDLE:    if (cap_start) state <= ST_DELAY;
                ST_DELAY:   if (filt_done) state <= ST_CONFIRM;
                ST_CONFIRM: state <= (sync[1] == dir_q) ? ST_CAP : ST_IDLE; // glitch drops
                ST_CAP:     state <= ST_IDLE;
                default:    state <= ST_IDLE;
            endcase
        end
    end

    assign cap_evt = (state == ST_CAP) && !cfg.cap_cmp_sel;

    // shadow follows cmp_val only at a period boundary
    always_ff @(posedge clk)
    begin
        if (!running || expired)
            cmp_shadow <= cfg.cmp_val;
    end

    assign cmp_active = running && cfg.cmp_oen && cfg.cap_cmp_sel;

    always_comb
    begin
        case (cfg.oc_mode)
            timer_pkg::OC_GEQ_HIGH: cmp_next = cnt >= cmp_shadow;
            timer_pkg::OC_LT_HIGH:  cmp_next = cnt < cmp_shadow;
            default:                cmp_next = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            cmp_out   <= 1'b0;
            cap_cmp_t <= 1'b1; // pad is an input after reset
        end
        else
        begin
            cmp_out   <= cmp_active && cmp_next;
            cap_cmp_t <= !cmp_active;
        end
    end

    // no capture in compare mode, also in the cycle after a switch
    assert property (@(posedge clk) disable iff (!resetn)
        cfg.cap_cmp_sel |-> !cap_evt ##1 !cap_evt);

    // filter state always a known encoding
    assert property (@(posedge clk) disable iff (!resetn)
        !$isunknown(state));

endmodule

/* logic/timer_pkg.sv */
/* timer_pkg
   widths, register map, mode encodings and the capture event record of the timer */
package timer_pkg;

    localparam int TIMER_W     = 16; // counter and capture width
    localparam int NUM_CH      = 2;
    localparam int CH_W        = 1;  // channel index bits
    localparam int FILT_W      = 8;  // glitch filter threshold
    localparam int QUEUE_DEPTH = 4;  // must stay a power of two
    localparam int QPTR_W      = $clog2(QUEUE_DEPTH);
    localparam int ADDR_W      = 4;

    // register map, write only
    localparam logic [ADDR_W-1:0] REG_CTRL    = 4'd0; // bit 0 enable and bit 1 ovf clear
    localparam logic [ADDR_W-1:0] REG_PSC     = 4'd1;
    localparam logic [ADDR_W-1:0] REG_ARR     = 4'd2;
    localparam logic [ADDR_W-1:0] REG_CH_CTRL = 4'd4; // plus 2 per channel
    localparam logic [ADDR_W-1:0] REG_CH_CMP  = 4'd5; // plus 2 per channel

    // output compare modes, codes 2 and 3 keep the pin low
    typedef enum logic [1:0] {
        OC_GEQ_HIGH = 2'b00, // high while cnt >= compare
        OC_LT_HIGH  = 2'b01, // high while cnt < compare
        OC_LOW_2    = 2'b10,
        OC_LOW_3    = 2'b11
    } oc_mode_e;

    typedef enum logic [1:0] {
        EDGE_RISE = 2'b00,
        EDGE_FALL = 2'b01,
        EDGE_BOTH = 2'b10,
        EDGE_NONE = 2'b11 // reserved, never captures
    } cap_edge_e;

    // one queued capture
    typedef struct packed {
        logic [CH_W-1:0]    chan;
        logic [TIMER_W-1:0] value;
    } cap_event_t;

endpackage

/* logic/timer_top.sv */
`timescale 1ns/100ps
/* timer_top
   16-bit timer with two capture/compare channels and a queued capture output */
module timer_top (
    input  logic                          clk,
    input  logic                          resetn,
    input  logic                          cfg_valid,
    input  logic [timer_pkg::ADDR_W-1:0]  cfg_addr,
    input  logic [timer_pkg::TIMER_W-1:0] cfg_data,
    output logic                          cap_valid,
    input  logic                          cap_ready,
    output logic [timer_pkg::CH_W-1:0]    cap_chan,
    output logic [timer_pkg::TIMER_W-1:0] cap_value,
    input  logic [timer_pkg::NUM_CH-1:0]  cap_in,
    output logic [timer_pkg::NUM_CH-1:0]  cmp_out,
    output logic [timer_pkg::NUM_CH-1:0]  cap_cmp_t,
    output logic                          ovf
);

    logic                          enable;
    logic [timer_pkg::TIMER_W-1:0] psc;
    logic [timer_pkg::TIMER_W-1:0] arr;
    logic                          ovf_clr;
    logic [timer_pkg::TIMER_W-1:0] cnt;
    logic                          running;
    logic                          expired;
    logic [timer_pkg::NUM_CH-1:0]  cap_evt;
    logic [timer_pkg::TIMER_W-1:0] cap_val [timer_pkg::NUM_CH];

    chan_cfg_if ch_cfg [timer_pkg::NUM_CH] (); // one per channel

    timer_cfg_regs i_regs (
        .clk, .resetn, .cfg_valid, .cfg_addr, .cfg_data,
        .enable, .psc, .arr, .ovf_clr,
        .ch_cfg (ch_cfg)
    );

    timer_counter i_counter (
        .clk, .resetn, .enable, .psc, .arr,
        .cnt, .running, .expired
    );

    for (genvar g = 0; g < timer_pkg::NUM_CH; g++)
    begin : g_chan
        timer_ic_oc i_ch (
            .clk, .resetn,
            .cap_in    (cap_in[g]),
            .cmp_out   (cmp_out[g]),
            .cap_cmp_t (cap_cmp_t[g]),
            .cnt, .running, .expired,
            .cfg       (ch_cfg[g]),
            .cap_evt   (cap_evt[g]),
            .cap_val   (cap_val[g])
        );
    end

    cap_event_queue i_queue (
        .clk, .resetn, .cap_evt, .cap_val, .ovf_clr,
        .cap_valid, .cap_ready, .cap_chan, .cap_value, .ovf
    );

endmodule
